/* design/fwdPkg.sv */
// Forwarding source codes shared by the operand forward RTL and its testbench.
// Import with fwdPkg::* wherever a forward code is decoded or generated.

package fwdPkg;

  // ##############################
  // functional units and codes
  // ##############################

  localparam int fuCount = 10;      // units that can forward a result.
  localparam int fwdCodeWidth = 4;

  typedef logic [fwdCodeWidth-1:0] fwdCodeT;

  localparam fwdCodeT fwdNone = 4'hf;                         // no forward this cycle.
  localparam fwdCodeT fwdLastUnit = fwdCodeT'(fuCount - 1);

  // Codes 0 to 8 name their own unit, and the spare codes 9 to 14 all fold onto unit 9.
  // The result has no meaning for fwdNone, so callers check fwdValid first.
  function automatic fwdCodeT fwdUnit(fwdCodeT code);
    return (code < fwdLastUnit) ? code : fwdLastUnit;
  endfunction

  function automatic logic fwdValid(fwdCodeT code);
    return code != fwdNone;
  endfunction

endpackage

/* design/operandPkg.sv */
// Operand width and payload types for the reservation station forward stage.
// Every RTL file that carries an operand imports operandPkg::*.

package operandPkg;

  import fwdPkg::*;

  // taken from the ALU datapath width.
  localparam int operandWidth = 65;

  typedef logic [operandWidth-1:0] operandT;

  // One result per functional unit, unit 0 in the low slot.
  typedef operandT [fuCount-1:0] fuOperandsT;

  localparam operandT operandZero = '0;   // reset value of a held operand.

endpackage

/* design/fwdSourceSelect.sv */
// Forward source selector: decodes one forward code and picks that unit's value.
// Used twice, once for this cycle's results and once for the registered results.

module fwdSourceSelect
  import fwdPkg::*;
  import operandPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fwdCodeT    code,
  input  fuOperandsT fuData,
  input  logic       auxEn,
  input  operandT    auxData,
  output operandT    selData,
  output logic       hit
);

  logic [fuCount-1:0] unitSel;   // one-hot unit select, all zero on fwdNone.
  operandT            unitData;

  // ##############################
  // code decode
  // ##############################

  assign hit = fwdValid(code);

  always_comb begin
    for (int i = 0; i < fuCount; i++) begin
      unitSel[i] = hit && (fwdUnit(code) == fwdCodeT'(i));
    end
  end

  // ##############################
  // and-or data select
  // ##############################

  // With a one-hot select the OR tree acts as a plain mux, and
  // no unit contributes anything when the code is fwdNone.
  always_comb begin
    unitData = operandZero;
    for (int i = 0; i < fuCount; i++) begin
      unitData = unitData | (fuData[i] & {operandWidth{unitSel[i]}});
    end
  end

  // the jump-and-link-register path brings its own value in place of the unit result.
  assign selData = auxEn ? auxData : unitData;

  // ##############################
  // checks
  // ##############################

  // An unknown code would make the hit flag and the select disagree downstream.
  codeKnown: assert property (
    @(posedge clk) disable iff (rst) !$isunknown(code)
  ) else $error("forward code is unknown");

  // The override is only asked for on a slot that is actually forwarding.
  auxNeedsCode: assert property (
    @(posedge clk) disable iff (rst) auxEn |-> fwdValid(code)
  ) else $error("aux override without a forward code");

endmodule

/* design/operandLatch.sv */
// Operand register of the forward stage.
// Merges the two selector outputs with the held operand and registers under stall.

module operandLatch
  import operandPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    stall,
  input  operandT oldData,
  input  operandT fuData,
  input  logic    fuHit,
  input  operandT fuuData,
  input  logic    fuuHit,
  output operandT newData
);

  operandT nextData;

  // ##############################
  // next operand
  // ##############################

  // at most one hit is set, so the order here only matters for illegal cycles.
  always_comb begin
    if (fuHit) begin
      nextData = fuData;       // result produced this cycle.
    end else if (fuuHit) begin
      nextData = fuuData;      // registered result or aux value.
    end else begin
      nextData = oldData;
    end
  end

  // ##############################
  // register
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      newData <= operandZero;
    end else if (!stall) begin
      newData <= nextData;
    end
  end

  // ##############################
  // checks
  // ##############################

  // The issue logic names one source per operand, so the two selectors never
  // forward in the same cycle.
  singleSource: assert property (
    @(posedge clk) disable iff (rst) !(fuHit && fuuHit)
  ) else $error("both forward paths hit in one cycle");

endmodule

/* design/rsOperandForward.sv */
// Reservation station operand write-forward stage, top level.
// Picks this cycle's result, last cycle's result, an aux value or the held operand.

module rsOperandForward
  import fwdPkg::*;
  import operandPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       stall,
  input  operandT    oldData,
  input  fwdCodeT    fuCode,
  input  fwdCodeT    fuuCode,
  input  logic       auxEn,
  input  operandT    auxData,
  input  fuOperandsT fuResult,
  input  fuOperandsT fuResultReg,
  output operandT    newData
);

  operandT fuData;
  logic    fuHit;
  operandT fuuData;
  logic    fuuHit;

  // ##############################
  // source selectors
  // ##############################

  // Results on the unit outputs this cycle. The aux override never applies here.
  fwdSourceSelect u_fuSelect (
    .clk     (clk),
    .rst     (rst),
    .code    (fuCode),
    .fuData  (fuResult),
    .auxEn   (1'b0),
    .auxData (operandZero),
    .selData (fuData),
    .hit     (fuHit)
  );

  // Results from one cycle back, with the jump-and-link-register aux override.
  fwdSourceSelect u_fuuSelect (
    .clk     (clk),
    .rst     (rst),
    .code    (fuuCode),
    .fuData  (fuResultReg),
    .auxEn   (auxEn),
    .auxData (auxData),
    .selData (fuuData),
    .hit     (fuuHit)
  );

  // ##############################
  // operand register
  // ##############################

  operandLatch u_latch (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .oldData (oldData),
    .fuData  (fuData),
    .fuHit   (fuHit),
    .fuuData (fuuData),
    .fuuHit  (fuuHit),
    .newData (newData)
  );

endmodule

/* tb/tbRsOperandForward.sv */
// Testbench for the reservation station operand forward stage.
// Replays tb/forwardVectors.txt with random unit results and checks newData every cycle.

module tbRsOperandForward
  import fwdPkg::*;
  import operandPkg::*;
();

  localparam int maxLines = 512;   // bound on the vector file read loop.

  logic       clk = 1'b0;
  logic       rst;
  logic       stall;
  operandT    oldData;
  fwdCodeT    fuCode;
  fwdCodeT    fuuCode;
  logic       auxEn;
  operandT    auxData;
  fuOperandsT fuResult;
  fuOperandsT fuResultReg;
  operandT    newData;

  // one entry per cycle, in file order.
  logic    vStall[$];
  fwdCodeT vFuCode[$];
  fwdCodeT vFuuCode[$];
  logic    vAuxEn[$];
  operandT vAuxData[$];
  operandT vOldData[$];

  operandT    expData;      // value newData must show after the latest edge.
  operandT    nextExp;
  fuOperandsT nextRes;
  fuOperandsT nextResReg;

  always #50 clk = ~clk;

  rsOperandForward u_rsOperandForward (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .oldData     (oldData),
    .fuCode      (fuCode),
    .fuuCode     (fuuCode),
    .auxEn       (auxEn),
    .auxData     (auxData),
    .fuResult    (fuResult),
    .fuResultReg (fuResultReg),
    .newData     (newData)
  );

  // ##############################
  // reference model
  // ##############################

  function automatic operandT randOperand();
    logic [95:0] bits;
    bits = {$urandom(), $urandom(), $urandom()};
    return bits[operandWidth-1:0];
  endfunction

  // codes above 8 are spares that all belong to the last unit.
  function automatic int unitIndex(fwdCodeT code);
    if (code <= 4'd8) begin
      return int'(code);
    end
    return fuCount - 1;
  endfunction

  function automatic operandT modelNext(
    logic       isStalled,
    fwdCodeT    fc,
    fwdCodeT    fuc,
    logic       ae,
    operandT    ad,
    operandT    od,
    fuOperandsT res,
    fuOperandsT resReg,
    operandT    held
  );
    if (isStalled) begin
      return held;
    end
    if (fc != fwdNone) begin
      return res[unitIndex(fc)];     // this cycle's result wins.
    end
    if (fuc != fwdNone) begin
      return ae ? ad : resReg[unitIndex(fuc)];
    end
    return od;
  endfunction

  // ##############################
  // checks and file reading
  // ##############################

  task automatic stopRun();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(string name, operandT expected, operandT actual);
    if (actual !== expected) begin
      $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic loadVectors();
    int      fd;
    int      lines;
    int      got;
    string   line;
    logic    st;
    fwdCodeT fc;
    fwdCodeT fuc;
    logic    ae;
    operandT ad;
    operandT od;
    fd = $fopen("tb/forwardVectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tb/forwardVectors.txt");
      stopRun();
    end
    lines = 0;
    while (!$feof(fd)) begin
      lines++;
      if (lines > maxLines) begin
        $display("vector file still not read after %0d lines", maxLines);
        stopRun();
      end
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() < 4 || line.substr(0, 1) == "//") begin
        continue;                    // comment or blank line.
      end
      got = $sscanf(line, "%h %h %h %h %h %h", st, fc, fuc, ae, ad, od);
      if (got != 6) begin
        $display("vector line %0d has %0d fields instead of 6", lines, got);
        stopRun();
      end
      vStall.push_back(st);
      vFuCode.push_back(fc);
      vFuuCode.push_back(fuc);
      vAuxEn.push_back(ae);
      vAuxData.push_back(ad);
      vOldData.push_back(od);
    end
    $fclose(fd);
    if (vStall.size() == 0) begin
      $display("the vector file holds no vectors");
      stopRun();
    end
  endtask

  // ##############################
  // stimulus
  // ##############################

  initial begin
    rst         = 1'b1;
    stall       = 1'b0;
    oldData     = '1;               // all ones, so a missing reset would show up.
    fuCode      = fwdNone;
    fuuCode     = fwdNone;
    auxEn       = 1'b0;
    auxData     = operandZero;
    fuResult    = '0;
    fuResultReg = '0;
    expData     = operandZero;
    nextExp     = operandZero;
    void'($urandom(10));
    loadVectors();

    repeat (2) @(posedge clk);
    rst     <= 1'b0;
    oldData <= operandZero;
    @(negedge clk);
    checkValue("newData", operandZero, newData);   // reset value.

    foreach (vStall[i]) begin
      @(posedge clk);                    // this edge takes the previous inputs.
      for (int u = 0; u < fuCount; u++) begin
        nextRes[u]    = randOperand();
        nextResReg[u] = randOperand();
      end
      stall       <= vStall[i];
      fuCode      <= vFuCode[i];
      fuuCode     <= vFuuCode[i];
      auxEn       <= vAuxEn[i];
      auxData     <= vAuxData[i];
      oldData     <= vOldData[i];
      fuResult    <= nextRes;
      fuResultReg <= nextResReg;
      nextExp = modelNext(vStall[i], vFuCode[i], vFuuCode[i], vAuxEn[i], vAuxData[i],
                          vOldData[i], nextRes, nextResReg, expData);
      @(negedge clk);
      checkValue("newData", expData, newData);
      expData = nextExp;
    end

    // The last vector lands on this edge, then the stage sits stalled.
    @(posedge clk);
    stall   <= 1'b1;
    fuCode  <= fwdNone;
    fuuCode <= fwdNone;
    auxEn   <= 1'b0;
    @(negedge clk);
    checkValue("newData", expData, newData);
    @(posedge clk);
    @(negedge clk);
    checkValue("newData", expData, newData);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* tb/forwardVectors.txt */
// columns: stall fuCode fuuCode auxEn auxData oldData, all hex, one cycle per line.
// code f means no forward, and fuCode and fuuCode never both name a unit.
0 f f 0 00000000000000000 0123456789abcdef0
0 0 f 0 00000000000000000 1111111111111111a
0 1 f 0 0000000000000dead 02222222222222222
0 2 f 0 00000000000000000 13333333333333333
0 3 f 0 00000000000000000 04444444444444444
0 4 f 0 00000000000000000 15555555555555555
0 5 f 0 00000000000000000 06666666666666666
0 6 f 0 00000000000000000 17777777777777777
0 7 f 0 00000000000000000 08888888888888888
0 8 f 0 00000000000000000 19999999999999999
0 9 f 0 00000000000000000 0aaaaaaaaaaaaaaaa
0 a f 0 00000000000000000 1bbbbbbbbbbbbbbbb
0 b f 0 00000000000000000 0cccccccccccccccc
0 c f 0 00000000000000000 1dddddddddddddddd
0 d f 0 00000000000000000 0eeeeeeeeeeeeeeee
0 e f 0 00000000000000000 1ffffffffffffffff
1 f f 0 00000000000000000 00000000000000001
1 3 f 0 00000000000000000 00000000000000002
1 f 5 1 1cafecafecafecafe 00000000000000003
0 f 0 0 00000000000000000 00000000000000004
0 f 4 0 00000000000000000 00000000000000005
0 f 9 0 00000000000000000 00000000000000006
0 f c 0 00000000000000000 00000000000000007
0 f 2 1 0123456789abcdef0 00000000000000008
0 f e 1 1fedcba9876543210 00000000000000009
0 f 7 1 00000000000000001 0000000000000000a
0 f f 0 00000000000000000 10000000000000000
0 f f 0 0beefbeefbeefbeef 05a5a5a5a5a5a5a5a
1 f f 0 00000000000000000 1a5a5a5a5a5a5a5a5
1 f 8 0 00000000000000000 03c3c3c3c3c3c3c3c
0 f 8 0 00000000000000000 13c3c3c3c3c3c3c3c
0 6 f 0 00000000000000000 00f0f0f0f0f0f0f0f
0 f 1 1 10000000000000001 00000000000000000
1 0 f 0 00000000000000000 0ffffffffffffffff
0 f f 0 00000000000000000 12468ace13579bdf0
0 e f 0 00000000000000000 00000000000000000

/* tb.f */
design/fwdPkg.sv
design/operandPkg.sv
design/fwdSourceSelect.sv
design/operandLatch.sv
design/rsOperandForward.sv
tb/tbRsOperandForward.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tbRsOperandForward
FILELIST  := tb.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

SOURCES   := $(wildcard design/*.sv) $(wildcard tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the simulation reads its vectors relative to the project root.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
